/* vs_macros.svh */
`ifndef VS_MACROS_SVH
`define VS_MACROS_SVH

// Capture memory geometry

// Stored samples, seven banks
`define VS_RAM_DEPTH 7168

// Words in one bank
`define VS_BANK_WORDS 1024

// Covers VS_RAM_DEPTH
`define VS_ADDR_W 13

// Sample width from the ADC front end
`define VS_DATA_W 12

`endif

/* vs_pkg.sv */
`include "vs_macros.svh"

package vs_pkg;

  typedef logic [`VS_DATA_W-1:0] sample_t;
  typedef logic [`VS_ADDR_W-1:0] vs_addr_t;

  // Static setup, held while a capture runs
  typedef struct packed {
    sample_t  threshold;
    vs_addr_t post_count;  // Samples kept after the trigger sample
  } vs_cfg_t;

  typedef struct packed {
    logic     en;
    vs_addr_t addr;
    sample_t  data;
  } vs_wr_t;

  // Offset counted from the oldest stored sample
  typedef struct packed {
    vs_addr_t offset;
  } vs_rd_req_t;

  typedef struct packed {
    sample_t data;
    logic    is_trig;
  } vs_rd_resp_t;

  typedef struct packed {
    logic armed;
    logic triggered;
    logic done;
  } vs_status_t;

endpackage

/* hs_slave.sv */
module hs_slave #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  input  payload_t payload,
  input  logic     done_in,
  output logic     ack,
  output logic     take,
  output payload_t data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,   // Client working on the payload
    ST_ACKED   // Waiting for req to fall
  } state_e;

  state_e state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      take  <= 1'b0;
    end else begin
      take <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_BUSY;
            take  <= 1'b1;  // Single strobe per handshake
          end
        end
        ST_BUSY: begin
          if (done_in) state <= ST_ACKED;
        end
        ST_ACKED: begin
          if (!req) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload held for the client until the next handshake
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) data <= payload;
  end

  assign ack = (state == ST_ACKED);

endmodule

/* vs_infrastructure.sv */
`include "vs_macros.svh"

module vs_infrastructure #(
  parameter int RAM_HIGH = `VS_RAM_DEPTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  vs_pkg::vs_wr_t   wr,
  input  vs_pkg::vs_addr_t raddr,
  output vs_pkg::sample_t  rdata
);

  import vs_pkg::*;

  localparam int OFF_W     = $clog2(`VS_BANK_WORDS);
  localparam int SEL_W     = `VS_ADDR_W - OFF_W;
  localparam int NUM_BANKS = (RAM_HIGH - 1) / `VS_BANK_WORDS + 1;  // Round up

  logic [SEL_W-1:0]     wsel;
  logic [SEL_W-1:0]     rsel_q;
  logic [NUM_BANKS-1:0] bank_we;
  sample_t              bank_q [NUM_BANKS];

  assign wsel = wr.addr[`VS_ADDR_W-1:OFF_W];  // Upper bits pick the bank

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    sample_t mem [`VS_BANK_WORDS];

    assign bank_we[b] = wr.en && (wsel == SEL_W'(b));

    always_ff @(posedge clk) begin
      if (bank_we[b]) begin
        mem[wr.addr[OFF_W-1:0]] <= wr.data;
      end
      bank_q[b] <= mem[raddr[OFF_W-1:0]];  // Old data on a same-address write
    end
  end

  // Bank select follows the bank outputs by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsel_q <= '0;
    end else begin
      rsel_q <= raddr[`VS_ADDR_W-1:OFF_W];
    end
  end

  // Addresses past the last bank read as zero
  assign rdata = (rsel_q < NUM_BANKS) ? bank_q[rsel_q] : '0;

endmodule

/* vs_trigger.sv */
module vs_trigger (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             arm,
  input  vs_pkg::vs_cfg_t  cfg,
  input  vs_pkg::vs_wr_t   wr,
  output logic             trig_hit,
  output logic             triggered,
  output vs_pkg::vs_addr_t trig_addr
);

  import vs_pkg::*;

  logic    armed;
  logic    prev_vld;  // First sample after arm has no predecessor
  sample_t prev;

  // Rising crossing on the sample being written this cycle
  assign trig_hit = armed && !triggered && wr.en && prev_vld &&
                    (prev < cfg.threshold) && (wr.data >= cfg.threshold);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      triggered <= 1'b0;
      prev_vld  <= 1'b0;
      trig_addr <= '0;
    end else if (arm) begin
      armed     <= 1'b1;
      triggered <= 1'b0;
      prev_vld  <= 1'b0;
    end else begin
      if (wr.en) prev_vld <= 1'b1;
      if (trig_hit) begin
        triggered <= 1'b1;
        trig_addr <= wr.addr;  // Where the trigger sample lands
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) prev <= wr.data;
  end

endmodule

/* vs_capture.sv */
`include "vs_macros.svh"

module vs_capture (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             arm,
  input  vs_pkg::vs_cfg_t  cfg,
  input  logic             samp_take,
  input  vs_pkg::sample_t  samp,
  input  logic             trig_hit,
  output vs_pkg::vs_wr_t   wr,
  output vs_pkg::vs_addr_t stop_ptr,
  output logic             armed,
  output logic             done
);

  import vs_pkg::*;

  vs_addr_t wptr;
  vs_addr_t wptr_nxt;
  vs_addr_t remain;    // Post-trigger samples still to write
  logic     post_run;

  // Only an armed capture writes, later samples are dropped
  assign wr = '{en: samp_take && armed, addr: wptr, data: samp};

  assign wptr_nxt = (wptr == vs_addr_t'(`VS_RAM_DEPTH - 1)) ? '0 : wptr + 1'b1;

  assign stop_ptr = wptr;  // Oldest sample once stopped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr     <= '0;
      remain   <= '0;
      post_run <= 1'b0;
      armed    <= 1'b0;
      done     <= 1'b0;
    end else begin
      if (wr.en) wptr <= wptr_nxt;

      if (arm) begin
        armed    <= 1'b1;
        done     <= 1'b0;
        post_run <= 1'b0;
      end else if (trig_hit) begin
        // Trigger sample is written on this edge
        if (cfg.post_count == '0) begin
          armed <= 1'b0;
          done  <= 1'b1;
        end else begin
          post_run <= 1'b1;
          remain   <= cfg.post_count;
        end
      end else if (post_run && wr.en) begin
        remain <= remain - 1'b1;
        if (remain == vs_addr_t'(1)) begin
          post_run <= 1'b0;
          armed    <= 1'b0;
          done     <= 1'b1;
        end
      end
    end
  end

endmodule

/* vs_readout.sv */
`include "vs_macros.svh"

module vs_readout (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rd_take,
  input  vs_pkg::vs_rd_req_t  rd_cmd,
  input  vs_pkg::vs_addr_t    stop_ptr,
  input  vs_pkg::vs_addr_t    trig_addr,
  input  logic                triggered,
  input  vs_pkg::sample_t     rdata,
  output vs_pkg::vs_addr_t    raddr,
  output logic                rd_done,
  output vs_pkg::vs_rd_resp_t rd_resp
);

  import vs_pkg::*;

  logic [`VS_ADDR_W:0] sum;  // One extra bit for the wrap
  logic                is_trig_q;

  assign sum = {1'b0, stop_ptr} + {1'b0, rd_cmd.offset};

  // Offsets count forward from the oldest sample
  assign raddr = (sum >= `VS_RAM_DEPTH) ? vs_addr_t'(sum - `VS_RAM_DEPTH)
                                        : vs_addr_t'(sum);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_done   <= 1'b0;
      is_trig_q <= 1'b0;
    end else begin
      rd_done <= rd_take;  // Memory data valid in this cycle
      if (rd_take) begin
        is_trig_q <= triggered && (raddr == trig_addr);
      end
    end
  end

  // Held until the next read completes
  always_ff @(posedge clk) begin
    if (rd_done) begin
      rd_resp <= '{data: rdata, is_trig: is_trig_q};
    end
  end

endmodule

/* vs_top.sv */
module vs_top (
  input  logic                clk,
  input  logic                rst_n,
  input  vs_pkg::vs_cfg_t     cfg,
  input  logic                arm,
  input  logic                samp_req,
  input  vs_pkg::sample_t     samp,
  output logic                samp_ack,
  input  logic                rd_req,
  input  vs_pkg::vs_rd_req_t  rd_cmd,
  output logic                rd_ack,
  output vs_pkg::vs_rd_resp_t rd_resp,
  output vs_pkg::vs_status_t  status
);

  import vs_pkg::*;

  logic       samp_take;
  sample_t    samp_q;
  logic       rd_take;
  logic       rd_done;
  vs_rd_req_t rd_cmd_q;
  vs_wr_t     wr;
  vs_addr_t   raddr;
  sample_t    rdata;
  vs_addr_t   stop_ptr;
  vs_addr_t   trig_addr;
  logic       trig_hit;
  logic       triggered;
  logic       cap_armed;
  logic       cap_done;

  // Sample link acks right after the write, never stalls
  hs_slave #(.payload_t(sample_t)) u_samp_hs (
    .clk(clk), .rst_n(rst_n), .req(samp_req), .payload(samp), .done_in(samp_take),
    .ack(samp_ack), .take(samp_take), .data(samp_q)
  );

  hs_slave #(.payload_t(vs_rd_req_t)) u_rd_hs (
    .clk(clk), .rst_n(rst_n), .req(rd_req), .payload(rd_cmd), .done_in(rd_done),
    .ack(rd_ack), .take(rd_take), .data(rd_cmd_q)
  );

  vs_trigger u_trigger (
    .clk(clk), .rst_n(rst_n), .arm(arm), .cfg(cfg), .wr(wr),
    .trig_hit(trig_hit), .triggered(triggered), .trig_addr(trig_addr)
  );

  vs_capture u_capture (
    .clk(clk), .rst_n(rst_n), .arm(arm), .cfg(cfg), .samp_take(samp_take), .samp(samp_q),
    .trig_hit(trig_hit), .wr(wr), .stop_ptr(stop_ptr), .armed(cap_armed), .done(cap_done)
  );

  vs_readout u_readout (
    .clk(clk), .rst_n(rst_n), .rd_take(rd_take), .rd_cmd(rd_cmd_q), .stop_ptr(stop_ptr),
    .trig_addr(trig_addr), .triggered(triggered), .rdata(rdata), .raddr(raddr),
    .rd_done(rd_done), .rd_resp(rd_resp)
  );

  vs_infrastructure u_mem (
    .clk(clk), .rst_n(rst_n), .wr(wr), .raddr(raddr), .rdata(rdata)
  );

  assign status = '{armed: cap_armed, triggered: triggered, done: cap_done};

endmodule

/* tb_vs_top.sv */
`include "vs_macros.svh"

module tb_vs_top;
  timeunit 1ns;
  timeprecision 100ps;

  import vs_pkg::*;

  localparam int DEPTH      = `VS_RAM_DEPTH;
  localparam int STREAM_CAP = 9000;  // Samples per capture at most
  localparam int N_READ     = 300;
  localparam int N_HS       = 2 * STREAM_CAP + 50 + 2 * (N_READ + 1) + 50;
  localparam int LIMIT      = N_HS * 8 + 20000;

  logic        clk;
  logic        rst_n;
  vs_cfg_t     cfg;
  logic        arm;
  logic        samp_req;
  sample_t     samp;
  logic        samp_ack;
  logic        rd_req;
  vs_rd_req_t  rd_cmd;
  logic        rd_ack;
  vs_rd_resp_t rd_resp;
  vs_status_t  status;

  // Reference model of memory and capture state
  sample_t model_mem [DEPTH];
  int      m_wptr;
  int      m_count;  // Valid words, saturates at DEPTH
  int      m_remain;
  int      m_trig_addr;
  logic    m_armed;
  logic    m_trig;
  logic    m_done;
  logic    m_prev_vld;
  sample_t m_prev;

  logic [31:0] rng;
  int          n_checks;
  int          val_errs;
  int          other_errs;

  vs_top u_vs_top (
    .clk(clk), .rst_n(rst_n), .cfg(cfg), .arm(arm), .samp_req(samp_req), .samp(samp),
    .samp_ack(samp_ack), .rd_req(rd_req), .rd_cmd(rd_cmd), .rd_ack(rd_ack),
    .rd_resp(rd_resp), .status(status)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      val_errs++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic arm_capture(input sample_t th, input vs_addr_t post);
    @(negedge clk);
    cfg = '{threshold: th, post_count: post};
    arm = 1'b1;
    @(negedge clk);
    arm = 1'b0;
    m_armed    = 1'b1;
    m_trig     = 1'b0;
    m_done     = 1'b0;
    m_prev_vld = 1'b0;  // No predecessor right after arm
    check_eq("status after arm", 32'h4, status);
  endtask

  task automatic model_write(input sample_t s);
    if (m_armed) begin
      model_mem[m_wptr] = s;
      if (m_trig) begin
        m_remain--;
      end else if (m_prev_vld && m_prev < cfg.threshold && s >= cfg.threshold) begin
        m_trig      = 1'b1;
        m_trig_addr = m_wptr;
        m_remain    = cfg.post_count;
      end
      if (m_trig && m_remain == 0) begin
        m_done  = 1'b1;
        m_armed = 1'b0;
      end
      m_prev     = s;
      m_prev_vld = 1'b1;
      m_wptr     = (m_wptr + 1) % DEPTH;
      if (m_count < DEPTH) m_count++;
    end
  endtask

  task automatic send_sample(input sample_t s);
    int cyc;
    @(negedge clk);
    samp     = s;
    samp_req = 1'b1;
    cyc      = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!samp_ack);
    check_eq("sample ack latency", 2, cyc);
    model_write(s);
    check_eq("status after sample", {29'b0, m_armed, m_trig, m_done}, status);
    samp_req = 1'b0;
    while (samp_ack) @(negedge clk);
  endtask

  task automatic read_offset(input int off);
    int cyc;
    int addr;
    addr = (m_wptr + off) % DEPTH;  // Model write pointer is the oldest sample
    @(negedge clk);
    rd_cmd = '{offset: vs_addr_t'(off)};
    rd_req = 1'b1;
    cyc    = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!rd_ack);
    check_eq("read ack latency", 3, cyc);
    check_eq("read data", model_mem[addr], rd_resp.data);
    check_eq("trigger flag", m_trig && addr == m_trig_addr, rd_resp.is_trig);
    rd_req = 1'b0;
    while (rd_ack) @(negedge clk);
  endtask

  // Offsets limited to the words written so far
  task automatic read_random(input int n);
    int off;
    repeat (n) begin
      off = DEPTH - 1 - int'(next_rand() % m_count);
      read_offset(off);
    end
  endtask

  task automatic read_trigger();
    assert (m_trig) else begin
      other_errs++;
      $display("no trigger sample in the model capture");
    end
    read_offset((m_trig_addr - m_wptr + DEPTH) % DEPTH);
  endtask

  task automatic stream_until_done();
    int n;
    n = 0;
    while (!m_done && n < STREAM_CAP) begin
      send_sample(sample_t'(next_rand()));
      n++;
    end
    assert (m_done) else begin
      other_errs++;
      $display("capture did not finish within %0d samples", STREAM_CAP);
    end
  endtask

  initial begin
    rng         = 32'h4a33;
    n_checks    = 0;
    val_errs    = 0;
    other_errs  = 0;
    rst_n       = 1'b0;
    cfg         = '0;
    arm         = 1'b0;
    samp_req    = 1'b0;
    samp        = '0;
    rd_req      = 1'b0;
    rd_cmd      = '0;
    m_wptr      = 0;
    m_count     = 0;
    m_remain    = 0;
    m_trig_addr = 0;
    m_armed     = 1'b0;
    m_trig      = 1'b0;
    m_done      = 1'b0;
    m_prev_vld  = 1'b0;
    m_prev      = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    check_eq("reset samp_ack", 0, samp_ack);
    check_eq("reset rd_ack", 0, rd_ack);
    check_eq("reset status", 0, status);

    arm_capture(sample_t'(512 + next_rand() % 3072), vs_addr_t'(100 + next_rand() % 900));
    stream_until_done();
    read_random(N_READ);
    read_trigger();

    repeat (50) send_sample(sample_t'(next_rand()));  // Dropped, still acked
    read_random(50);

    // Long post count wraps through every bank
    arm_capture(sample_t'(512 + next_rand() % 3072), vs_addr_t'(DEPTH - 1 - next_rand() % 64));
    stream_until_done();
    read_random(N_READ);
    read_trigger();

    $display("checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
vs_pkg.sv
hs_slave.sv
vs_infrastructure.sv
vs_trigger.sv
vs_capture.sv
vs_readout.sv
vs_top.sv
tb_vs_top.sv
